/* common/mem_pkg.sv */
package mem_pkg;

    // Datapath and register file
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // Data RAM geometry, word addressed
    localparam int RAM_DEPTH   = 256;
    localparam int RAM_IDX_W   = 8;
    localparam int RAM_IDX_LSB = 2;    // Byte offset bits are ignored

    // Cycles from request capture to the done pulse
    localparam int RAM_LATENCY = 3;
    localparam int RAM_CNT_W   = 2;    // Must hold RAM_LATENCY-1

    // Memory stage access FSM
    typedef enum logic
    {
        MS_IDLE = 1'b0,    // Ready to accept an instruction
        MS_WAIT = 1'b1     // Waiting for the data RAM
    } mem_state_e;

    // Data RAM FSM
    typedef enum logic
    {
        RAM_IDLE = 1'b0,
        RAM_BUSY = 1'b1
    } ram_state_e;

endpackage

/* common/dmem_if.sv */
`timescale 1ns/1ps

// Request link between the memory stage and the data RAM.
// Plain pulses, one request in flight at a time.
interface dmem_if;
    import mem_pkg::*;

    logic            req;      // One-cycle request pulse
    logic            we;       // Store when high
    logic [XLEN-1:0] addr;     // Byte address, held until done
    logic [XLEN-1:0] wdata;
    logic [XLEN-1:0] rdata;    // Valid in the done cycle
    logic            done;     // One-cycle completion pulse

    modport stage
    (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport ram
    (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

/* memory/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic [mem_pkg::XLEN-1:0]       addr,
    input  logic [mem_pkg::XLEN-1:0]       data_in,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic                           in_mem_to_reg,
    input  logic                           in_reg_write,
    input  logic [mem_pkg::REG_ADDR_W-1:0] in_reg_dest,
    input  logic                           in_pc_src,
    input  logic [mem_pkg::XLEN-1:0]       in_branch_target,
    dmem_if.stage                          dmem,
    output logic                           stall_pipeline,
    output logic [mem_pkg::XLEN-1:0]       mem_data,
    output logic [mem_pkg::XLEN-1:0]       alu_result,
    output logic                           out_mem_to_reg,
    output logic                           out_reg_write,
    output logic [mem_pkg::REG_ADDR_W-1:0] out_reg_dest,
    output logic                           out_pc_src,
    output logic [mem_pkg::XLEN-1:0]       out_branch_target
);
    import mem_pkg::*;

    mem_state_e      state;
    logic [XLEN-1:0] addr_q;     // Registered ALU result, also the RAM address
    logic [XLEN-1:0] data_q;     // Store data held for the RAM
    logic            req_q;
    logic            we_q;
    logic            accept;
    logic            is_mem_op;

    assign is_mem_op = mem_read | mem_write;
    assign accept    = (state == MS_IDLE) && !stall;    // External stall only blocks new work

    // The pipeline is held for as long as an access is outstanding
    assign stall_pipeline = (state == MS_WAIT);

    assign dmem.req   = req_q;
    assign dmem.we    = we_q;
    assign dmem.addr  = addr_q;
    assign dmem.wdata = data_q;
    assign alu_result = addr_q;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state             <= MS_IDLE;
            req_q             <= 1'b0;
            we_q              <= 1'b0;
            addr_q            <= '0;
            data_q            <= '0;
            mem_data          <= '0;
            out_mem_to_reg    <= 1'b0;
            out_reg_write     <= 1'b0;
            out_reg_dest      <= '0;
            out_pc_src        <= 1'b0;
            out_branch_target <= '0;
        end
        else
        begin
            req_q <= 1'b0;    // Request is a single pulse
            case (state)
                MS_IDLE:
                begin
                    if (accept)
                    begin
                        addr_q            <= addr;
                        data_q            <= data_in;
                        we_q              <= mem_write;
                        out_mem_to_reg    <= in_mem_to_reg;
                        out_reg_write     <= in_reg_write;
                        out_reg_dest      <= in_reg_dest;
                        out_pc_src        <= in_pc_src;
                        out_branch_target <= in_branch_target;
                        if (is_mem_op)
                        begin
                            req_q <= 1'b1;
                            state <= MS_WAIT;
                        end
                    end
                end
                MS_WAIT:
                begin
                    // Capture the word and release the pipeline on completion
                    if (dmem.done)
                    begin
                        mem_data <= dmem.rdata;
                        state    <= MS_IDLE;
                    end
                end
                default:
                begin
                    state <= MS_IDLE;
                end
            endcase
        end
    end

endmodule

/* memory/data_ram.sv */
`timescale 1ns/1ps

module data_ram
(
    input  logic clk,
    input  logic rst,
    dmem_if.ram  dmem
);
    import mem_pkg::*;

    logic [XLEN-1:0]      mem_array [RAM_DEPTH];
    ram_state_e           state;
    logic [RAM_CNT_W-1:0] cnt;          // Cycles spent in RAM_BUSY
    logic [RAM_IDX_W-1:0] idx_q;        // Latched word index
    logic                 we_q;
    logic [XLEN-1:0]      wdata_q;
    logic                 last_cycle;

    assign last_cycle = (state == RAM_BUSY) && (cnt == RAM_CNT_W'(RAM_LATENCY - 1));

    assign dmem.done  = last_cycle;
    assign dmem.rdata = mem_array[idx_q];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= RAM_IDLE;
            cnt   <= '0;
        end
        else if (state == RAM_IDLE)
        begin
            if (dmem.req)
            begin
                state <= RAM_BUSY;
                cnt   <= '0;
            end
        end
        else if (last_cycle)
        begin
            state <= RAM_IDLE;
        end
        else
        begin
            cnt <= cnt + 1'b1;
        end
    end

    // Request fields are held for the whole access
    always_ff @(posedge clk)
    begin
        if (state == RAM_IDLE && dmem.req)
        begin
            idx_q   <= dmem.addr[RAM_IDX_LSB +: RAM_IDX_W];
            we_q    <= dmem.we;
            wdata_q <= dmem.wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (last_cycle && we_q)
            mem_array[idx_q] <= wdata_q;    // Store lands at the end of the done cycle
    end

endmodule

/* logic/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall_pipeline,
    input  logic                           mem_to_reg,
    input  logic                           reg_write,
    input  logic [mem_pkg::REG_ADDR_W-1:0] reg_dest,
    input  logic [mem_pkg::XLEN-1:0]       mem_data,
    input  logic [mem_pkg::XLEN-1:0]       alu_result,
    output logic                           wr_en,
    output logic [mem_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic [mem_pkg::XLEN-1:0]       wr_data
);
    import mem_pkg::*;

    logic [XLEN-1:0] result;

    // Loaded word or ALU result
    assign result = mem_to_reg ? mem_data : alu_result;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wr_en   <= 1'b0;
            wr_addr <= '0;
            wr_data <= '0;
        end
        else if (stall_pipeline)
        begin
            wr_en <= 1'b0;    // Memory stage outputs are not final yet
        end
        else
        begin
            wr_en   <= reg_write;
            wr_addr <= reg_dest;
            wr_data <= result;
        end
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [mem_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [mem_pkg::XLEN-1:0]       wr_data,
    input  logic [mem_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic [mem_pkg::XLEN-1:0]       rd_data
);
    import mem_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en && (wr_addr != '0))
        begin
            regs[wr_addr] <= wr_data;    // Register 0 stays zero
        end
    end

    // Asynchronous read for the decode side
    assign rd_data = regs[rd_addr];

endmodule

/* logic/mem_subsystem_top.sv */
`timescale 1ns/1ps

module mem_subsystem_top
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           stall,
    input  logic [mem_pkg::XLEN-1:0]       addr,
    input  logic [mem_pkg::XLEN-1:0]       data_in,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic                           mem_to_reg,
    input  logic                           reg_write,
    input  logic [mem_pkg::REG_ADDR_W-1:0] reg_dest,
    input  logic                           pc_src,
    input  logic [mem_pkg::XLEN-1:0]       branch_target,
    input  logic [mem_pkg::REG_ADDR_W-1:0] rd_addr,
    output logic                           stall_pipeline,
    output logic                           pc_src_out,
    output logic [mem_pkg::XLEN-1:0]       branch_target_out,
    output logic [mem_pkg::XLEN-1:0]       alu_result,
    output logic [mem_pkg::REG_ADDR_W-1:0] rd_data_unused_never,
    output logic [mem_pkg::XLEN-1:0]       rd_data
);
    import mem_pkg::*;

    logic [XLEN-1:0]       mem_data;
    logic                  ms_mem_to_reg;
    logic                  ms_reg_write;
    logic [REG_ADDR_W-1:0] ms_reg_dest;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;

    dmem_if dmem_bus ();

    memory_stage memory_stage_i
    (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .addr              (addr),
        .data_in           (data_in),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .in_mem_to_reg     (mem_to_reg),
        .in_reg_write      (reg_write),
        .in_reg_dest       (reg_dest),
        .in_pc_src         (pc_src),
        .in_branch_target  (branch_target),
        .dmem              (dmem_bus.stage),
        .stall_pipeline    (stall_pipeline),
        .mem_data          (mem_data),
        .alu_result        (alu_result),
        .out_mem_to_reg    (ms_mem_to_reg),
        .out_reg_write     (ms_reg_write),
        .out_reg_dest      (ms_reg_dest),
        .out_pc_src        (pc_src_out),
        .out_branch_target (branch_target_out)
    );

    data_ram data_ram_i
    (
        .clk  (clk),
        .rst  (rst),
        .dmem (dmem_bus.ram)
    );

    writeback_stage writeback_stage_i
    (
        .clk            (clk),
        .rst            (rst),
        .stall_pipeline (stall_pipeline),
        .mem_to_reg     (ms_mem_to_reg),
        .reg_write      (ms_reg_write),
        .reg_dest       (ms_reg_dest),
        .mem_data       (mem_data),
        .alu_result     (alu_result),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

    register_file register_file_i
    (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    assign rd_data_unused_never = wr_addr;

endmodule

/* bench/tb_mem_subsystem.sv */
`timescale 1ns/1ps

module tb_mem_subsystem;
    import mem_pkg::*;

    logic                  clk;
    logic                  rst;
    logic                  stall;
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       data_in;
    logic                  mem_read;
    logic                  mem_write;
    logic                  mem_to_reg;
    logic                  reg_write;
    logic [REG_ADDR_W-1:0] reg_dest;
    logic                  pc_src;
    logic [XLEN-1:0]       branch_target;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic                  stall_pipeline;
    logic                  pc_src_out;
    logic [XLEN-1:0]       branch_target_out;
    logic [XLEN-1:0]       alu_result;
    logic [REG_ADDR_W-1:0] wr_addr_mon;    // Writeback destination register
    logic [XLEN-1:0]       rd_data;

    int          error_count;
    int          timeout_count;
    logic [31:0] lcg_state;

    mem_subsystem_top mem_subsystem_top_i
    (
        .clk                  (clk),
        .rst                  (rst),
        .stall                (stall),
        .addr                 (addr),
        .data_in              (data_in),
        .mem_read             (mem_read),
        .mem_write            (mem_write),
        .mem_to_reg           (mem_to_reg),
        .reg_write            (reg_write),
        .reg_dest             (reg_dest),
        .pc_src               (pc_src),
        .branch_target        (branch_target),
        .rd_addr              (rd_addr),
        .stall_pipeline       (stall_pipeline),
        .pc_src_out           (pc_src_out),
        .branch_target_out    (branch_target_out),
        .alu_result           (alu_result),
        .rd_data_unused_never (wr_addr_mon),
        .rd_data              (rd_data)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        assert (actual === expected)
        else
        begin
            error_count++;
            $display("[ERROR] %s: expected 0x%08h, got 0x%08h", name, expected, actual);
        end
    endtask

    // Caller sits on a rising edge
    task automatic drive_instr(input logic [31:0] a, input logic [31:0] d, input logic rd_op,
                               input logic wr_op, input logic m2r, input logic rw,
                               input logic [4:0] dest, input logic ps, input logic [31:0] bt);
        addr          <= a;
        data_in       <= d;
        mem_read      <= rd_op;
        mem_write     <= wr_op;
        mem_to_reg    <= m2r;
        reg_write     <= rw;
        reg_dest      <= dest;
        pc_src        <= ps;
        branch_target <= bt;
        rd_addr       <= dest;    // Watch the destination register
    endtask

    task automatic drive_nop();
        drive_instr(32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, rd_addr, 1'b0, 32'h0);
    endtask

    // Returns at the acceptance edge
    task automatic issue_instr(input logic [31:0] a, input logic [31:0] d, input logic rd_op,
                               input logic wr_op, input logic m2r, input logic rw,
                               input logic [4:0] dest, input logic ps, input logic [31:0] bt);
        @(posedge clk);
        drive_instr(a, d, rd_op, wr_op, m2r, rw, dest, ps, bt);
        @(posedge clk);
        drive_nop();
    endtask

    task automatic wait_stall_low();
        int n;
        n = 0;
        @(negedge clk);
        while (stall_pipeline !== 1'b0 && n < 50)
        begin
            @(negedge clk);
            n++;
        end
        if (stall_pipeline !== 1'b0)
        begin
            timeout_count++;
            $display("Timeout: stall_pipeline did not fall within 50 cycles");
        end
    endtask

    task automatic count_stall_cycles(output int cycles);
        int   n;
        logic ended;
        n     = 0;
        ended = 1'b0;
        while (!ended && n < 50)
        begin
            @(negedge clk);
            if (stall_pipeline === 1'b1)
                n++;
            else
                ended = 1'b1;
        end
        if (!ended)
        begin
            timeout_count++;
            $display("Timeout: stall_pipeline stayed high for 50 cycles");
        end
        cycles = n;
    endtask

    task automatic read_reg(input logic [4:0] idx, input logic [31:0] expected);
        @(posedge clk);
        rd_addr <= idx;
        @(negedge clk);
        check_value("rd_data", rd_data, expected);
    endtask

    task automatic reset_check();
        @(negedge clk);
        check_value("stall_pipeline", 32'(stall_pipeline), 32'h0);
        check_value("pc_src_out", 32'(pc_src_out), 32'h0);
        check_value("alu_result", alu_result, 32'h0);
        read_reg(5'd0, 32'h0);
        read_reg(5'd1, 32'h0);
        read_reg(5'd17, 32'h0);
        read_reg(5'd31, 32'h0);
    endtask

    task automatic alu_writeback_check();
        logic [31:0] value;
        value = next_rand();
        issue_instr(value, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd5, 1'b0, 32'h0);
        @(negedge clk);
        check_value("alu_result", alu_result, value);
        @(negedge clk);
        check_value("wr_addr_mon", 32'(wr_addr_mon), 32'd5);    // Destination in writeback
        @(negedge clk);
        check_value("rd_data", rd_data, value);
        value = next_rand();
        issue_instr(value, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd0, 1'b0, 32'h0);
        repeat (3) @(negedge clk);
        check_value("rd_data", rd_data, 32'h0);    // r0 ignores writes
    endtask

    task automatic store_load_check();
        logic [XLEN-1:0] addrs [4];
        logic [XLEN-1:0] words [4];
        addrs[0] = 32'h0000_0040;    // Word indices 0x10, 0x23, 0x7f, 0xc4
        addrs[1] = 32'h0000_008c;
        addrs[2] = 32'h0000_01fc;
        addrs[3] = 32'h0000_0310;
        for (int i = 0; i < 4; i++)
        begin
            words[i] = next_rand();
            issue_instr(addrs[i], words[i], 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 1'b0, 32'h0);
            wait_stall_low();
        end
        // Low address bits vary per load and select the same word
        for (int i = 0; i < 4; i++)
        begin
            issue_instr(addrs[i] | 32'(i), 32'h0, 1'b1, 1'b0, 1'b1, 1'b1,
                        REG_ADDR_W'(10 + i), 1'b0, 32'h0);
            wait_stall_low();
            repeat (2) @(negedge clk);
            check_value("rd_data", rd_data, words[i]);
        end
    endtask

    task automatic stall_timing_check();
        int cycles;
        issue_instr(32'h0000_0040, 32'h0, 1'b1, 1'b0, 1'b1, 1'b1, 5'd20, 1'b0, 32'h0);
        count_stall_cycles(cycles);
        check_value("stall_pipeline cycles (load)", 32'(cycles), 32'd4);
        issue_instr(32'h0000_0200, next_rand(), 1'b0, 1'b1, 1'b0, 1'b0, 5'd0, 1'b0, 32'h0);
        count_stall_cycles(cycles);
        check_value("stall_pipeline cycles (store)", 32'(cycles), 32'd4);
    endtask

    task automatic branch_passthrough_check();
        logic [31:0] target;
        target = next_rand();
        issue_instr(32'h0, 32'h0, 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 1'b1, target);
        @(negedge clk);
        check_value("pc_src_out", 32'(pc_src_out), 32'h1);
        check_value("branch_target_out", branch_target_out, target);
        @(negedge clk);
        check_value("pc_src_out", 32'(pc_src_out), 32'h0);    // Following NOP clears it
    endtask

    task automatic external_stall_check();
        logic [31:0] old_value;
        logic [31:0] new_value;
        old_value = next_rand();
        new_value = next_rand();
        @(posedge clk);
        drive_instr(old_value, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd7, 1'b0, 32'h0);
        @(posedge clk);    // Accepted here and kept on the inputs
        repeat (3) @(negedge clk);
        check_value("rd_data", rd_data, old_value);
        @(posedge clk);
        stall <= 1'b1;
        drive_instr(new_value, 32'h0, 1'b0, 1'b0, 1'b0, 1'b1, 5'd7, 1'b0, 32'h0);
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            check_value("alu_result", alu_result, old_value);
            check_value("rd_data", rd_data, old_value);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);    // New instruction accepted here
        drive_nop();
        @(negedge clk);
        check_value("alu_result", alu_result, new_value);
        repeat (2) @(negedge clk);
        check_value("rd_data", rd_data, new_value);
    endtask

    initial
    begin
        error_count   = 0;
        timeout_count = 0;
        lcg_state     = 32'd9842;
        clk           = 1'b0;
        rst           = 1'b1;
        stall         = 1'b0;
        addr          = '0;
        data_in       = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_to_reg    = 1'b0;
        reg_write     = 1'b0;
        reg_dest      = '0;
        pc_src        = 1'b0;
        branch_target = '0;
        rd_addr       = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        reset_check();
        alu_writeback_check();
        store_load_check();
        stall_timing_check();
        branch_passthrough_check();
        external_stall_check();

        $display("Summary: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* build.f */
common/mem_pkg.sv
common/dmem_if.sv
memory/memory_stage.sv
memory/data_ram.sv
logic/writeback_stage.sv
logic/register_file.sv
logic/mem_subsystem_top.sv
bench/tb_mem_subsystem.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - common/mem_pkg.sv
  - common/dmem_if.sv
  - memory/memory_stage.sv
  - memory/data_ram.sv
  - logic/writeback_stage.sv
  - logic/register_file.sv
  - logic/mem_subsystem_top.sv
  - target: test
    files:
      - bench/tb_mem_subsystem.sv
